// File: can_rx_pkg.sv
`default_nettype none

package can_rx_pkg;

	// field lengths in bits, stuff bits excluded
	localparam int LEN_ID_A = 11;
	localparam int LEN_ID_B = 18;
	localparam int LEN_DLC = 4;
	localparam int LEN_CRC = 15;
	localparam int LEN_EOF = 7;
	localparam int LEN_INTERFRAME = 3;
	localparam int MAX_DATA_BYTES = 8;

	// x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1, top term implied
	localparam logic [14:0] CRC15_POLY = 15'h4599;

	// one state per frame field
	typedef enum logic [4:0] {
		ST_IDLE,
		ST_ID_A,
		ST_SRR_RTR,
		ST_IDE,
		ST_ID_B,
		ST_RTR,
		ST_R1,
		ST_R0,
		ST_DLC,
		ST_DATA,
		ST_CRC,
		ST_CRC_DELIM,
		ST_ACK_SLOT,
		ST_ACK_DELIM,
		ST_EOF,
		ST_INTERFRAME,
		ST_RECOVER
	} can_state_e;

	typedef enum logic [2:0] {
		ERR_NONE,
		ERR_STUFF,
		ERR_FORM,
		ERR_ACK,
		ERR_CRC
	} can_err_e;

	// captured fields of one frame
	typedef struct packed {
		logic ide;
		logic rtr;
		logic [10:0] id_a;
		logic [17:0] id_b;
		logic [3:0] dlc;
		logic [63:0] data;
		logic [14:0] crc;
	} can_frame_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// register map
	localparam logic [7:0] REG_CTRL = 8'h00;
	localparam logic [7:0] REG_STATUS = 8'h04;
	localparam logic [7:0] REG_ID = 8'h08;
	localparam logic [7:0] REG_DLC = 8'h0C;
	localparam logic [7:0] REG_DATA_LO = 8'h10;
	localparam logic [7:0] REG_DATA_HI = 8'h14;
	localparam logic [7:0] REG_ERR_COUNT = 8'h18;

endpackage

`default_nettype wire

// File: can_bit_destuffer.sv
`timescale 1ns/10ps
`default_nettype none

module can_bit_destuffer
(
	input wire logic clock,
	input wire logic reset,
	input wire logic rx_bit,
	input wire logic sample_point,
	input wire logic stuff_region,
	output logic bit_valid,
	output logic stuff_error
);

	// level of the current run
	logic last_bit;
	// number of equal bits in the current run
	logic [2:0] run_count;
	logic run_full;
	logic stuff_bit;

	// five equal bits seen, this sample has to be the complement
	assign run_full = stuff_region && (run_count == 3'd5);
	assign stuff_bit = run_full && (rx_bit != last_bit);
	// sixth equal bit in a row
	assign stuff_error = sample_point && run_full && (rx_bit == last_bit);
	// stuff bits never reach the decoder or the crc
	assign bit_valid = sample_point && !stuff_bit;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			last_bit <= 1'b1;
			run_count <= 3'd0;
		end
		else if (!stuff_region)
		begin
			// outside the stuffed part of the frame
			run_count <= 3'd0;
		end
		else if (sample_point)
		begin
			if (run_count == 3'd0 || rx_bit != last_bit)
			begin
				// level change, the dropped stuff bit included, opens a run of one
				last_bit <= rx_bit;
				run_count <= 3'd1;
			end
			else if (!run_full)
			begin
				run_count <= run_count + 3'd1;
			end
		end
	end

	// decoder relies on bits arriving only on a strobe
	assert property (@(posedge clock) disable iff (reset) bit_valid |-> sample_point);

endmodule

`default_nettype wire

// File: can_crc15.sv
`timescale 1ns/10ps
`default_nettype none

module can_crc15
(
	input wire logic clock,
	input wire logic reset,
	input wire logic crc_init,
	input wire logic crc_run,
	input wire logic bit_valid,
	input wire logic rx_bit,
	output logic [14:0] crc_value
);

	logic feedback;

	// incoming bit against the bit shifted out
	assign feedback = rx_bit ^ crc_value[14];

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			crc_value <= 15'h0;
		end
		else if (crc_init)
		begin
			// idle, SOF is dominant so it adds nothing anyway
			crc_value <= 15'h0;
		end
		else if (crc_run && bit_valid)
		begin
			crc_value <= {crc_value[13:0], 1'b0}
				^ (feedback ? can_rx_pkg::CRC15_POLY : 15'h0);
		end
	end

endmodule

`default_nettype wire

// File: can_frame_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module can_frame_decoder
(
	input wire logic clock,
	input wire logic reset,
	input wire logic rx_enable,
	input wire logic rx_bit,
	input wire logic sample_point,
	input wire logic bit_valid,
	input wire logic stuff_error,
	input wire logic [14:0] crc_value,
	output logic stuff_region,
	output logic crc_init,
	output logic crc_run,
	output can_rx_pkg::can_frame_t frame,
	output logic frame_done,
	output can_rx_pkg::can_err_e err_code,
	output logic err_done
);

	can_rx_pkg::can_state_e state;
	can_rx_pkg::can_state_e state_next;
	// shared bit counter, reused by every multi-bit field
	logic [6:0] bit_cnt;
	logic [6:0] cnt_next;
	logic err_det;
	can_rx_pkg::can_err_e err_kind;
	logic eof_done;
	logic start_frame;
	// bit after identifier A, SRR or RTR
	logic srr_bit;
	logic [3:0] dlc_shift;
	logic [6:0] data_len;
	logic [5:0] data_idx;
	logic sof_seen;

	// dominant bit on an idle bus
	assign sof_seen = (state == can_rx_pkg::ST_IDLE) && rx_enable && !rx_bit;
	assign start_frame = sof_seen && bit_valid;

	// destuffing covers SOF to the CRC, plus a stuff bit trailing the last CRC bit
	assign stuff_region = sof_seen || (state inside {[can_rx_pkg::ST_ID_A:can_rx_pkg::ST_CRC_DELIM]});
	assign crc_init = (state == can_rx_pkg::ST_IDLE);
	assign crc_run = sof_seen || (state inside {[can_rx_pkg::ST_ID_A:can_rx_pkg::ST_DATA]});

	assign dlc_shift = {frame.dlc[2:0], rx_bit};
	// dlc above 8 still means 8 bytes
	assign data_len = (frame.dlc > 4'(can_rx_pkg::MAX_DATA_BYTES))
		? 7'(can_rx_pkg::MAX_DATA_BYTES * 8) : {frame.dlc, 3'b000};
	// first data bit lands in bit 63
	assign data_idx = 6'd63 - bit_cnt[5:0];

	always_comb
	begin
		state_next = state;
		cnt_next = bit_cnt;
		err_det = 1'b0;
		err_kind = can_rx_pkg::ERR_NONE;
		eof_done = 1'b0;
		if (stuff_error)
		begin
			err_det = 1'b1;
			err_kind = can_rx_pkg::ERR_STUFF;
		end
		else if (bit_valid)
		begin
			case (state)
				can_rx_pkg::ST_IDLE:
				begin
					if (!rx_bit)
					begin
						state_next = can_rx_pkg::ST_ID_A;
						cnt_next = 7'd0;
					end
				end
				can_rx_pkg::ST_ID_A:
				begin
					if (bit_cnt == 7'(can_rx_pkg::LEN_ID_A - 1))
						state_next = can_rx_pkg::ST_SRR_RTR;
					cnt_next = bit_cnt + 7'd1;
				end
				can_rx_pkg::ST_SRR_RTR:
					state_next = can_rx_pkg::ST_IDE;
				can_rx_pkg::ST_IDE:
				begin
					if (!rx_bit)
					begin
						// base frame, no r1
						state_next = can_rx_pkg::ST_R0;
					end
					else if (!srr_bit)
					begin
						// srr has to be recessive in an extended frame
						err_det = 1'b1;
						err_kind = can_rx_pkg::ERR_FORM;
					end
					else
					begin
						state_next = can_rx_pkg::ST_ID_B;
						cnt_next = 7'd0;
					end
				end
				can_rx_pkg::ST_ID_B:
				begin
					if (bit_cnt == 7'(can_rx_pkg::LEN_ID_B - 1))
						state_next = can_rx_pkg::ST_RTR;
					cnt_next = bit_cnt + 7'd1;
				end
				can_rx_pkg::ST_RTR:
					state_next = can_rx_pkg::ST_R1;
				can_rx_pkg::ST_R1:
					state_next = can_rx_pkg::ST_R0;
				can_rx_pkg::ST_R0:
				begin
					state_next = can_rx_pkg::ST_DLC;
					cnt_next = 7'd0;
				end
				can_rx_pkg::ST_DLC:
				begin
					cnt_next = bit_cnt + 7'd1;
					if (bit_cnt == 7'(can_rx_pkg::LEN_DLC - 1))
					begin
						cnt_next = 7'd0;
						// remote frame or zero length skips the data field
						if (frame.rtr || dlc_shift == 4'd0)
							state_next = can_rx_pkg::ST_CRC;
						else
							state_next = can_rx_pkg::ST_DATA;
					end
				end
				can_rx_pkg::ST_DATA:
				begin
					cnt_next = bit_cnt + 7'd1;
					if (bit_cnt == data_len - 7'd1)
					begin
						state_next = can_rx_pkg::ST_CRC;
						cnt_next = 7'd0;
					end
				end
				can_rx_pkg::ST_CRC:
				begin
					if (bit_cnt == 7'(can_rx_pkg::LEN_CRC - 1))
						state_next = can_rx_pkg::ST_CRC_DELIM;
					cnt_next = bit_cnt + 7'd1;
				end
				can_rx_pkg::ST_CRC_DELIM:
				begin
					if (!rx_bit)
					begin
						err_det = 1'b1;
						err_kind = can_rx_pkg::ERR_FORM;
					end
					else if (frame.crc != crc_value)
					begin
						err_det = 1'b1;
						err_kind = can_rx_pkg::ERR_CRC;
					end
					else
						state_next = can_rx_pkg::ST_ACK_SLOT;
				end
				can_rx_pkg::ST_ACK_SLOT:
				begin
					// nobody acknowledged
					if (rx_bit)
					begin
						err_det = 1'b1;
						err_kind = can_rx_pkg::ERR_ACK;
					end
					else
						state_next = can_rx_pkg::ST_ACK_DELIM;
				end
				can_rx_pkg::ST_ACK_DELIM:
				begin
					if (!rx_bit)
					begin
						err_det = 1'b1;
						err_kind = can_rx_pkg::ERR_FORM;
					end
					else
					begin
						state_next = can_rx_pkg::ST_EOF;
						cnt_next = 7'd0;
					end
				end
				can_rx_pkg::ST_EOF:
				begin
					cnt_next = bit_cnt + 7'd1;
					if (!rx_bit)
					begin
						err_det = 1'b1;
						err_kind = can_rx_pkg::ERR_FORM;
					end
					else if (bit_cnt == 7'(can_rx_pkg::LEN_EOF - 1))
					begin
						state_next = can_rx_pkg::ST_INTERFRAME;
						cnt_next = 7'd0;
						eof_done = 1'b1;
					end
				end
				can_rx_pkg::ST_INTERFRAME:
				begin
					cnt_next = bit_cnt + 7'd1;
					if (!rx_bit)
					begin
						err_det = 1'b1;
						err_kind = can_rx_pkg::ERR_FORM;
					end
					else if (bit_cnt == 7'(can_rx_pkg::LEN_INTERFRAME - 1))
						state_next = can_rx_pkg::ST_IDLE;
				end
				can_rx_pkg::ST_RECOVER:
				begin
					// seven recessive in a row, a dominant restarts the count
					cnt_next = rx_bit ? bit_cnt + 7'd1 : 7'd0;
					if (rx_bit && bit_cnt == 7'(can_rx_pkg::LEN_EOF - 1))
						state_next = can_rx_pkg::ST_IDLE;
				end
				default:
					state_next = can_rx_pkg::ST_IDLE;
			endcase
		end
		if (err_det)
		begin
			state_next = can_rx_pkg::ST_RECOVER;
			cnt_next = 7'd0;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= can_rx_pkg::ST_IDLE;
			bit_cnt <= 7'd0;
			frame_done <= 1'b0;
			err_done <= 1'b0;
			err_code <= can_rx_pkg::ERR_NONE;
		end
		else if (!rx_enable)
		begin
			// receiver off, park in idle
			state <= can_rx_pkg::ST_IDLE;
			bit_cnt <= 7'd0;
			frame_done <= 1'b0;
			err_done <= 1'b0;
		end
		else
		begin
			state <= state_next;
			bit_cnt <= cnt_next;
			frame_done <= eof_done;
			err_done <= err_det;
			if (err_det)
				err_code <= err_kind;
		end
	end

	// field shift registers, msb first
	always_ff @(posedge clock)
	begin
		if (start_frame)
		begin
			frame <= '0;
		end
		else if (bit_valid && !stuff_error)
		begin
			case (state)
				can_rx_pkg::ST_ID_A:
					frame.id_a <= {frame.id_a[9:0], rx_bit};
				can_rx_pkg::ST_SRR_RTR:
					srr_bit <= rx_bit;
				can_rx_pkg::ST_IDE:
				begin
					frame.ide <= rx_bit;
					// in a base frame the held bit was rtr
					if (!rx_bit)
						frame.rtr <= srr_bit;
				end
				can_rx_pkg::ST_ID_B:
					frame.id_b <= {frame.id_b[16:0], rx_bit};
				can_rx_pkg::ST_RTR:
					frame.rtr <= rx_bit;
				can_rx_pkg::ST_DLC:
					frame.dlc <= dlc_shift;
				can_rx_pkg::ST_DATA:
					frame.data[data_idx] <= rx_bit;
				can_rx_pkg::ST_CRC:
					frame.crc <= {frame.crc[13:0], rx_bit};
				default:
				begin
				end
			endcase
		end
	end

	// the register block counts each frame once, as good or as failed
	assert property (@(posedge clock) disable iff (reset) !(frame_done && err_done));

endmodule

`default_nettype wire

// File: can_rx_regs.sv
`timescale 1ns/10ps
`default_nettype none

module can_rx_regs
#(
	parameter int APB_ADDR_WIDTH = 8
)
(
	input wire logic clock,
	input wire logic reset,
	input wire can_rx_pkg::apb_req_t apb_req,
	output can_rx_pkg::apb_rsp_t apb_rsp,
	input wire can_rx_pkg::can_frame_t frame,
	input wire logic frame_done,
	input wire can_rx_pkg::can_err_e err_code,
	input wire logic err_done,
	output logic rx_enable
);

	logic [APB_ADDR_WIDTH-1:0] addr;
	logic wr_access;
	logic rd_access;
	logic ctrl_wr;
	logic status_wr;
	logic addr_hit;
	logic [31:0] rd_data;
	logic frame_valid;
	logic overrun;
	can_rx_pkg::can_err_e last_err;
	logic [15:0] err_count;
	// frame as seen by the host
	can_rx_pkg::can_frame_t frame_hold;
	logic [28:0] id_field;

	// offsets fit in the low address bits
	assign addr = apb_req.paddr[APB_ADDR_WIDTH-1:0];
	// writes land at the end of the access phase
	assign wr_access = apb_req.psel && apb_req.penable && apb_req.pwrite;
	assign rd_access = apb_req.psel && !apb_req.pwrite;
	assign ctrl_wr = wr_access && (addr == APB_ADDR_WIDTH'(can_rx_pkg::REG_CTRL));
	assign status_wr = wr_access && (addr == APB_ADDR_WIDTH'(can_rx_pkg::REG_STATUS));

	// extended id is A then B, base id right aligned
	assign id_field = frame_hold.ide ? {frame_hold.id_a, frame_hold.id_b}
		: {18'h0, frame_hold.id_a};

	always_comb
	begin
		rd_data = 32'h0;
		addr_hit = 1'b1;
		case (addr)
			APB_ADDR_WIDTH'(can_rx_pkg::REG_CTRL):
				rd_data = {31'h0, rx_enable};
			APB_ADDR_WIDTH'(can_rx_pkg::REG_STATUS):
				rd_data = {25'h0, last_err, 2'b00, overrun, frame_valid};
			APB_ADDR_WIDTH'(can_rx_pkg::REG_ID):
				rd_data = {frame_hold.ide, frame_hold.rtr, 1'b0, id_field};
			APB_ADDR_WIDTH'(can_rx_pkg::REG_DLC):
				rd_data = {28'h0, frame_hold.dlc};
			APB_ADDR_WIDTH'(can_rx_pkg::REG_DATA_LO):
				rd_data = frame_hold.data[31:0];
			APB_ADDR_WIDTH'(can_rx_pkg::REG_DATA_HI):
				rd_data = frame_hold.data[63:32];
			APB_ADDR_WIDTH'(can_rx_pkg::REG_ERR_COUNT):
				rd_data = {16'h0, err_count};
			default:
				addr_hit = 1'b0;
		endcase
	end

	// no wait states
	assign apb_rsp = '{
		prdata: rd_access ? rd_data : 32'h0,
		pready: 1'b1,
		pslverr: apb_req.psel && apb_req.penable && !addr_hit
	};

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rx_enable <= 1'b0;
			frame_valid <= 1'b0;
			overrun <= 1'b0;
			last_err <= can_rx_pkg::ERR_NONE;
			err_count <= 16'h0;
		end
		else
		begin
			if (ctrl_wr)
				rx_enable <= apb_req.pwdata[0];
			// write one to clear
			if (status_wr && apb_req.pwdata[0])
				frame_valid <= 1'b0;
			if (status_wr && apb_req.pwdata[1])
				overrun <= 1'b0;
			// a completing frame beats a clear in the same cycle
			if (frame_done)
			begin
				if (frame_valid)
					overrun <= 1'b1;
				else
					frame_valid <= 1'b1;
			end
			if (err_done)
				last_err <= err_code;
			if (ctrl_wr && apb_req.pwdata[1])
				err_count <= err_done ? 16'h1 : 16'h0;
			else if (err_done && err_count != 16'hffff)
				err_count <= err_count + 16'h1;
		end
	end

	// unread frame is kept, later ones dropped
	always_ff @(posedge clock)
	begin
		if (frame_done && !frame_valid)
			frame_hold <= frame;
	end

	assert property (@(posedge clock) disable iff (reset) apb_rsp.pready);

endmodule

`default_nettype wire

// File: can_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

module can_rx_top
#(
	parameter int APB_ADDR_WIDTH = 8
)
(
	input wire logic clock,
	input wire logic reset,
	input wire logic rx_bit,
	input wire logic sample_point,
	input wire can_rx_pkg::apb_req_t apb_req,
	output can_rx_pkg::apb_rsp_t apb_rsp
);

	logic rx_enable;
	// destuffer handshake
	logic stuff_region;
	logic bit_valid;
	logic stuff_error;
	// crc control and result
	logic crc_init;
	logic crc_run;
	logic [14:0] crc_value;
	// decoder results to the registers
	can_rx_pkg::can_frame_t frame;
	logic frame_done;
	can_rx_pkg::can_err_e err_code;
	logic err_done;

	can_rx_regs #(
		.APB_ADDR_WIDTH(APB_ADDR_WIDTH)
	) can_rx_regs_inst (
		.clock(clock),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.frame(frame),
		.frame_done(frame_done),
		.err_code(err_code),
		.err_done(err_done),
		.rx_enable(rx_enable)
	);

	can_frame_decoder can_frame_decoder_inst (
		.clock(clock),
		.reset(reset),
		.rx_enable(rx_enable),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.bit_valid(bit_valid),
		.stuff_error(stuff_error),
		.crc_value(crc_value),
		.stuff_region(stuff_region),
		.crc_init(crc_init),
		.crc_run(crc_run),
		.frame(frame),
		.frame_done(frame_done),
		.err_code(err_code),
		.err_done(err_done)
	);

	can_bit_destuffer can_bit_destuffer_inst (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.stuff_region(stuff_region),
		.bit_valid(bit_valid),
		.stuff_error(stuff_error)
	);

	can_crc15 can_crc15_inst (
		.clock(clock),
		.reset(reset),
		.crc_init(crc_init),
		.crc_run(crc_run),
		.bit_valid(bit_valid),
		.rx_bit(rx_bit),
		.crc_value(crc_value)
	);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
#(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 10
)
(
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever
			#(PERIOD_NS / 2) clock = ~clock;
	end

	// release lands just after a rising edge
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: tb_can_rx.sv
`timescale 1ns/10ps
`default_nettype none

module tb_can_rx;

	localparam int CLOCK_PERIOD_NS = 40;
	localparam int DRIVE_DELAY_NS = 2;
	localparam int CLOCKS_PER_BIT = 8;
	// sample strobe on the fourth clock of a bit
	localparam int SAMPLE_CLOCK = 3;
	localparam int FRAME_COUNT = 12;
	localparam int MAX_FRAME_BITS = 160;
	localparam int TIMEOUT_CYCLES = FRAME_COUNT * MAX_FRAME_BITS * CLOCKS_PER_BIT * 2;

	logic clock;
	logic reset;
	logic rx_bit;
	logic sample_point;
	can_rx_pkg::apb_req_t apb_req;
	can_rx_pkg::apb_rsp_t apb_rsp;

	// unstuffed SOF to CRC
	logic raw_bits [0:191];
	int raw_len;
	// bus sequence with stuff bits and the tail
	logic line_bits [0:255];
	int line_len;
	logic [31:0] rng_state;
	int error_count;
	int check_count;
	int cycle_count;

	tb_clock_gen #(
		.PERIOD_NS(CLOCK_PERIOD_NS),
		.RESET_CYCLES(10)
	) tb_clock_gen_inst (
		.clock(clock),
		.reset(reset)
	);

	can_rx_top #(
		.APB_ADDR_WIDTH(8)
	) can_rx_top_inst (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic can_rx_pkg::can_frame_t make_frame(input logic ide, input logic rtr,
		input logic [10:0] id_a, input logic [17:0] id_b, input logic [3:0] dlc,
		input logic [63:0] data);
		can_rx_pkg::can_frame_t f;
		f.ide = ide;
		f.rtr = rtr;
		f.id_a = id_a;
		f.id_b = id_b;
		f.dlc = dlc;
		f.data = data;
		f.crc = 15'h0;
		return f;
	endfunction

	// serial crc over the first count raw bits
	function automatic logic [14:0] crc_of_raw(input int count);
		logic [14:0] crc;
		logic feedback;
		int i;
		crc = 15'h0;
		for (i = 0; i < count; i++)
		begin
			feedback = raw_bits[i] ^ crc[14];
			crc = {crc[13:0], 1'b0};
			if (feedback)
				crc = crc ^ can_rx_pkg::CRC15_POLY;
		end
		return crc;
	endfunction

	task automatic step_cycle();
		@(posedge clock);
		#(DRIVE_DELAY_NS);
	endtask

	// random bytes from the top byte down, unused bytes zero
	task automatic make_payload(input int n_bytes, output logic [63:0] data);
		int k;
		data = 64'h0;
		for (k = 0; k < n_bytes; k++)
		begin
			rng_state = xorshift32(rng_state);
			data[63 - 8 * k -: 8] = rng_state[7:0];
		end
	endtask

	// msb first
	task automatic append_field(input logic [63:0] value, input int width);
		int i;
		for (i = width - 1; i >= 0; i--)
		begin
			raw_bits[raw_len] = value[i];
			raw_len++;
		end
	endtask

	task automatic push_line(input logic level);
		line_bits[line_len] = level;
		line_len++;
	endtask

	task automatic build_frame(input can_rx_pkg::can_frame_t f, input logic [14:0] crc_flip,
		input logic do_stuff, input logic ack_level, output can_rx_pkg::can_frame_t expected);
		int n_bits;
		int i;
		int run;
		logic last;
		logic [14:0] crc;
		raw_len = 0;
		// SOF
		append_field(64'h0, 1);
		append_field(64'(f.id_a), can_rx_pkg::LEN_ID_A);
		if (f.ide)
		begin
			// srr and ide recessive
			append_field(64'h3, 2);
			append_field(64'(f.id_b), can_rx_pkg::LEN_ID_B);
			append_field(64'(f.rtr), 1);
			// r1 and r0
			append_field(64'h0, 2);
		end
		else
		begin
			append_field(64'(f.rtr), 1);
			// ide and r0
			append_field(64'h0, 2);
		end
		append_field(64'(f.dlc), can_rx_pkg::LEN_DLC);
		n_bits = 0;
		if (!f.rtr)
			n_bits = ((f.dlc > 4'd8) ? 8 : int'(f.dlc)) * 8;
		append_field(f.data >> (64 - n_bits), n_bits);
		crc = crc_of_raw(raw_len);
		expected = f;
		expected.crc = crc;
		append_field(64'(crc ^ crc_flip), can_rx_pkg::LEN_CRC);
		// stuff bit after five equal bits, it starts a new run
		line_len = 0;
		run = 0;
		last = 1'b1;
		for (i = 0; i < raw_len; i++)
		begin
			if (run > 0 && raw_bits[i] == last)
			begin
				run++;
			end
			else
			begin
				last = raw_bits[i];
				run = 1;
			end
			push_line(raw_bits[i]);
			if (do_stuff && run == 5)
			begin
				last = !last;
				push_line(last);
				run = 1;
			end
		end
		// crc delimiter, ack slot, ack delimiter
		push_line(1'b1);
		push_line(ack_level);
		push_line(1'b1);
		for (i = 0; i < can_rx_pkg::LEN_EOF + can_rx_pkg::LEN_INTERFRAME; i++)
			push_line(1'b1);
	endtask

	task automatic send_bit(input logic level);
		int c;
		for (c = 0; c < CLOCKS_PER_BIT; c++)
		begin
			step_cycle();
			rx_bit = level;
			sample_point = (c == SAMPLE_CLOCK);
		end
	endtask

	task automatic send_frame();
		int i;
		for (i = 0; i < line_len; i++)
			send_bit(line_bits[i]);
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		step_cycle();
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b1;
		apb_req.paddr = addr;
		apb_req.pwdata = data;
		step_cycle();
		apb_req.penable = 1'b1;
		#(CLOCK_PERIOD_NS / 4);
		if (!apb_rsp.pready)
		begin
			error_count++;
			$display("pready low during a write to offset %h", addr);
		end
		if (apb_rsp.pslverr)
		begin
			error_count++;
			$display("slave error on a write to offset %h", addr);
		end
		step_cycle();
		apb_req = '0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		step_cycle();
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
		apb_req.paddr = addr;
		apb_req.pwdata = 32'h0;
		step_cycle();
		apb_req.penable = 1'b1;
		// mid access phase
		#(CLOCK_PERIOD_NS / 4);
		data = apb_rsp.prdata;
		if (!apb_rsp.pready)
		begin
			error_count++;
			$display("pready low during a read from offset %h", addr);
		end
		if (apb_rsp.pslverr)
		begin
			error_count++;
			$display("slave error on a read from offset %h", addr);
		end
		step_cycle();
		apb_req = '0;
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_err(input string name, input can_rx_pkg::can_err_e expected,
		input can_rx_pkg::can_err_e actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("[FAIL] %s: expected error %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_frame(input string name, input can_rx_pkg::can_frame_t expected,
		input can_rx_pkg::can_frame_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// polling loops are bounded by the watchdog
	task automatic wait_status(input int bit_index);
		logic [31:0] s;
		s = 32'h0;
		while (!s[bit_index])
			apb_read(can_rx_pkg::REG_STATUS, s);
	endtask

	task automatic wait_err_count(input logic [31:0] previous, output logic [31:0] count);
		count = previous;
		while (count == previous)
			apb_read(can_rx_pkg::REG_ERR_COUNT, count);
	endtask

	task automatic read_frame(output can_rx_pkg::can_frame_t f);
		logic [31:0] id_word;
		logic [31:0] dlc_word;
		logic [31:0] lo_word;
		logic [31:0] hi_word;
		can_rx_pkg::can_frame_t held;
		apb_read(can_rx_pkg::REG_ID, id_word);
		apb_read(can_rx_pkg::REG_DLC, dlc_word);
		apb_read(can_rx_pkg::REG_DATA_LO, lo_word);
		apb_read(can_rx_pkg::REG_DATA_HI, hi_word);
		f.ide = id_word[31];
		f.rtr = id_word[30];
		if (id_word[31])
		begin
			f.id_a = id_word[28:18];
			f.id_b = id_word[17:0];
		end
		else
		begin
			f.id_a = id_word[10:0];
			f.id_b = 18'h0;
		end
		f.dlc = dlc_word[3:0];
		f.data = {hi_word, lo_word};
		// crc has no register, taken from the held frame
		held = can_rx_top_inst.can_rx_regs_inst.frame_hold;
		f.crc = held.crc;
	endtask

	task automatic receive_and_check(input string name, input can_rx_pkg::can_frame_t expected);
		can_rx_pkg::can_frame_t actual;
		wait_status(0);
		read_frame(actual);
		check_frame(name, expected, actual);
	endtask

	task automatic test_enable_overrun();
		can_rx_pkg::can_frame_t first;
		can_rx_pkg::can_frame_t second;
		can_rx_pkg::can_frame_t actual;
		logic [63:0] data;
		logic [31:0] s;
		make_payload(2, data);
		build_frame(make_frame(1'b0, 1'b0, 11'h2a5, 18'h0, 4'd2, data), 15'h0, 1'b1, 1'b0, first);
		apb_write(can_rx_pkg::REG_CTRL, 32'h0);
		send_frame();
		apb_read(can_rx_pkg::REG_STATUS, s);
		check_word("enable_overrun disabled status", 32'h0, s);
		apb_write(can_rx_pkg::REG_CTRL, 32'h1);
		send_frame();
		wait_status(0);
		// second frame while the first is unread
		make_payload(1, data);
		build_frame(make_frame(1'b1, 1'b0, 11'h0f0, 18'h12345, 4'd1, data), 15'h0, 1'b1, 1'b0,
			second);
		send_frame();
		wait_status(1);
		apb_read(can_rx_pkg::REG_STATUS, s);
		check_word("enable_overrun status", 32'h3, s);
		read_frame(actual);
		check_frame("enable_overrun held frame", first, actual);
		apb_write(can_rx_pkg::REG_STATUS, 32'h3);
		apb_read(can_rx_pkg::REG_STATUS, s);
		check_word("enable_overrun cleared status", 32'h0, s);
	endtask

	task automatic test_standard_frame();
		can_rx_pkg::can_frame_t expected;
		logic [63:0] data;
		logic [31:0] s;
		make_payload(3, data);
		build_frame(make_frame(1'b0, 1'b0, 11'h123, 18'h0, 4'd3, data), 15'h0, 1'b1, 1'b0,
			expected);
		send_frame();
		receive_and_check("standard_frame", expected);
		apb_read(can_rx_pkg::REG_STATUS, s);
		check_word("standard_frame status", 32'h1, s & 32'h3);
		apb_read(can_rx_pkg::REG_ID, s);
		check_word("standard_frame id register", 32'h0000_0123, s);
		apb_write(can_rx_pkg::REG_STATUS, 32'h1);
		apb_read(can_rx_pkg::REG_STATUS, s);
		check_word("standard_frame cleared valid", 32'h0, s & 32'h1);
	endtask

	task automatic test_extended_frame();
		can_rx_pkg::can_frame_t expected;
		logic [63:0] data;
		logic [31:0] s;
		make_payload(8, data);
		build_frame(make_frame(1'b1, 1'b0, 11'h6b3, 18'h25c1a, 4'd8, data), 15'h0, 1'b1, 1'b0,
			expected);
		send_frame();
		receive_and_check("extended_frame", expected);
		apb_read(can_rx_pkg::REG_ID, s);
		check_word("extended_frame id register", {3'b100, 11'h6b3, 18'h25c1a}, s);
		apb_read(can_rx_pkg::REG_DATA_HI, s);
		check_word("extended_frame data hi", data[63:32], s);
		apb_read(can_rx_pkg::REG_DATA_LO, s);
		check_word("extended_frame data lo", data[31:0], s);
		apb_write(can_rx_pkg::REG_STATUS, 32'h3);
	endtask

	task automatic test_remote_frame();
		can_rx_pkg::can_frame_t expected;
		logic [63:0] data;
		logic [31:0] count_before;
		logic [31:0] count_after;
		apb_read(can_rx_pkg::REG_ERR_COUNT, count_before);
		build_frame(make_frame(1'b0, 1'b1, 11'h555, 18'h0, 4'd4, 64'h0), 15'h0, 1'b1, 1'b0,
			expected);
		send_frame();
		// data bits taken by mistake would show up as a crc error
		apb_read(can_rx_pkg::REG_ERR_COUNT, count_after);
		check_word("remote_frame error count", count_before, count_after);
		receive_and_check("remote_frame", expected);
		apb_write(can_rx_pkg::REG_STATUS, 32'h3);
		make_payload(6, data);
		build_frame(make_frame(1'b1, 1'b0, 11'h07e, 18'h3f00f, 4'd6, data), 15'h0, 1'b1, 1'b0,
			expected);
		send_frame();
		receive_and_check("remote_frame next frame", expected);
		apb_write(can_rx_pkg::REG_STATUS, 32'h3);
	endtask

	task automatic test_crc_error();
		can_rx_pkg::can_frame_t expected;
		logic [63:0] data;
		logic [31:0] s;
		logic [31:0] previous;
		logic [31:0] count;
		apb_read(can_rx_pkg::REG_ERR_COUNT, previous);
		make_payload(4, data);
		build_frame(make_frame(1'b0, 1'b0, 11'h3c1, 18'h0, 4'd4, data), 15'h0100, 1'b1, 1'b0,
			expected);
		send_frame();
		wait_err_count(previous, count);
		check_word("crc_error count", 32'h1, count);
		apb_read(can_rx_pkg::REG_STATUS, s);
		check_err("crc_error code", can_rx_pkg::ERR_CRC, can_rx_pkg::can_err_e'(s[6:4]));
		check_word("crc_error frame_valid", 32'h0, s & 32'h1);
		// frame tail leaves the bus recessive long enough to recover
		make_payload(5, data);
		build_frame(make_frame(1'b0, 1'b0, 11'h3c1, 18'h0, 4'd5, data), 15'h0, 1'b1, 1'b0,
			expected);
		send_frame();
		receive_and_check("crc_error good frame", expected);
		apb_write(can_rx_pkg::REG_STATUS, 32'h3);
	endtask

	task automatic test_stuff_and_ack_errors();
		can_rx_pkg::can_frame_t expected;
		logic [63:0] data;
		logic [31:0] s;
		logic [31:0] previous;
		logic [31:0] count;
		apb_read(can_rx_pkg::REG_ERR_COUNT, previous);
		// dominant identifier sent without stuff bits
		build_frame(make_frame(1'b0, 1'b0, 11'h000, 18'h0, 4'd0, 64'h0), 15'h0, 1'b0, 1'b0,
			expected);
		send_frame();
		wait_err_count(previous, count);
		check_word("stuff_error count", previous + 32'h1, count);
		apb_read(can_rx_pkg::REG_STATUS, s);
		check_err("stuff_error code", can_rx_pkg::ERR_STUFF, can_rx_pkg::can_err_e'(s[6:4]));
		previous = count;
		// nobody drives the ack slot
		make_payload(2, data);
		build_frame(make_frame(1'b0, 1'b0, 11'h1a7, 18'h0, 4'd2, data), 15'h0, 1'b1, 1'b1,
			expected);
		send_frame();
		wait_err_count(previous, count);
		check_word("ack_error count", previous + 32'h1, count);
		apb_read(can_rx_pkg::REG_STATUS, s);
		check_err("ack_error code", can_rx_pkg::ERR_ACK, can_rx_pkg::can_err_e'(s[6:4]));
		check_word("ack_error frame_valid", 32'h0, s & 32'h1);
	endtask

	// watchdog
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		rx_bit = 1'b1;
		sample_point = 1'b0;
		apb_req = '0;
		rng_state = 32'hda78_a286;
		error_count = 0;
		check_count = 0;
		@(negedge reset);
		// runs first while STATUS is still clean
		test_enable_overrun();
		test_standard_frame();
		test_extended_frame();
		test_remote_frame();
		test_crc_error();
		test_stuff_and_ack_errors();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
can_rx_pkg.sv
can_bit_destuffer.sv
can_crc15.sv
can_frame_decoder.sv
can_rx_regs.sv
can_rx_top.sv
tb_clock_gen.sv
tb_can_rx.sv
